//--- hqm_rf_pkg.sv
`default_nettype none

package hqm_rf_pkg;

    // ----------------------------------------------------------------------
    // Storage geometry
    // ----------------------------------------------------------------------

    // Number of entries held by the register file
    localparam int RF_DEPTH  = 256;
    // Entry address width, enough to reach every entry
    localparam int RF_ADDR_W = 8;
    // Functional data width seen by the queue manager
    localparam int RF_DATA_W = 129;
    // Physical array width, one spare bit above the functional word
    localparam int RF_WORD_W = 130;

    // ----------------------------------------------------------------------
    // Data path vectors
    // ----------------------------------------------------------------------

    typedef logic [RF_ADDR_W-1:0] rf_addr_t;
    typedef logic [RF_DATA_W-1:0] rf_data_t;
    typedef logic [RF_WORD_W-1:0] rf_word_t;

endpackage

`default_nettype wire

//--- hqm_rf_ctrl_pkg.sv
`default_nettype none

package hqm_rf_ctrl_pkg;

    // ----------------------------------------------------------------------
    // Initialization sequencing
    // ----------------------------------------------------------------------

    // States of the post-reset clear sequence
    // INIT_RESET waits for the first edge out of reset
    // INIT_CLEAR walks every entry and writes the clear value
    // INIT_DONE hands the array to the functional port for good
    typedef enum logic [1:0] {
        INIT_RESET = 2'd0,
        INIT_CLEAR = 2'd1,
        INIT_DONE  = 2'd2
    } init_state_t;

    // Word written to every entry during the sweep
    localparam hqm_rf_pkg::rf_data_t INIT_CLEAR_VALUE = '0;

endpackage

`default_nettype wire

//--- hqm_mem_reset_sync.sv
`timescale 1ns/1ps
`default_nettype none

module hqm_mem_reset_sync (
     input  logic rclk
    ,input  logic rst_n
    ,output logic rst_n_sync
);

    // Two-stage chain clocked by the read clock
    // A zero enters both stages together so assertion is immediate
    // A one has to ripple through both stages so release takes two edges
    logic [1:0] sync_q;

    always_ff @(posedge rclk) begin
        if (!rst_n) begin
            sync_q <= 2'b00;
        end else begin
            // Shift a constant one toward the output stage
            sync_q <= {sync_q[0], 1'b1};
        end
    end

    // The last stage is the reset seen by the array IP
    assign rst_n_sync = sync_q[1];

endmodule

`default_nettype wire

//--- hqm_rf_array.sv
`timescale 1ns/1ps
`default_nettype none

module hqm_rf_array #(
     parameter int ADDR_W = 8
    ,parameter int WORD_W = 130
) (
     input  logic              wclk
    ,input  logic              we
    ,input  logic [ADDR_W-1:0] waddr
    ,input  logic [WORD_W-1:0] wdata

    ,input  logic              rclk
    ,input  logic              re
    ,input  logic [ADDR_W-1:0] raddr
    ,input  logic              arr_rst_n

    ,output logic [WORD_W-1:0] dout
);

    // ----------------------------------------------------------------------
    // Storage
    // ----------------------------------------------------------------------

    // One word per address, contents are only defined once written
    logic [WORD_W-1:0] mem [2**ADDR_W];

    // Write port, the word lands on the same wclk edge that samples we
    always_ff @(posedge wclk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // ----------------------------------------------------------------------
    // Read port
    // ----------------------------------------------------------------------

    // Output register loads on an enabled read and holds otherwise
    // A write to the same address on the same edge is not visible yet
    // because the memory update and this load both use nonblocking order
    always_ff @(posedge rclk) begin
        if (!arr_rst_n) begin
            dout <= '0;
        end else if (re) begin
            dout <= mem[raddr];
        end
    end

endmodule

`default_nettype wire

//--- hqm_aw_rf_256x129.sv
`timescale 1ns/1ps
`default_nettype none

module hqm_aw_rf_256x129 (
     input  logic                 wclk
    ,input  logic                 we
    ,input  hqm_rf_pkg::rf_addr_t waddr
    ,input  hqm_rf_pkg::rf_data_t wdata

    ,input  logic                 rclk
    ,input  logic                 re
    ,input  hqm_rf_pkg::rf_addr_t raddr
    ,output hqm_rf_pkg::rf_data_t rdata

    ,input  logic                 ip_reset_b
);

    // Padded write word and raw read word at the physical width
    hqm_rf_pkg::rf_word_t wdata_word;
    hqm_rf_pkg::rf_word_t rdata_word;
    // Array reset after resynchronization onto rclk
    logic                 ip_reset_b_sync;

    // The spare top bit of the physical word is always written as zero
    assign wdata_word = {1'b0, wdata};

    // ----------------------------------------------------------------------
    // Array reset synchronizer
    // ----------------------------------------------------------------------

    hqm_mem_reset_sync i_ip_reset_b_sync (
         .rclk       (rclk)
        ,.rst_n      (ip_reset_b)
        ,.rst_n_sync (ip_reset_b_sync)
    );

    // ----------------------------------------------------------------------
    // Physical array
    // ----------------------------------------------------------------------

    hqm_rf_array #(
         .ADDR_W (hqm_rf_pkg::RF_ADDR_W)
        ,.WORD_W (hqm_rf_pkg::RF_WORD_W)
    ) i_rf (
         .wclk      (wclk)
        ,.we        (we)
        ,.waddr     (waddr)
        ,.wdata     (wdata_word)
        ,.rclk      (rclk)
        ,.re        (re)
        ,.raddr     (raddr)
        ,.arr_rst_n (ip_reset_b_sync)
        ,.dout      (rdata_word)
    );

    // Drop the spare bit on the way back out
    assign rdata = rdata_word[hqm_rf_pkg::RF_DATA_W-1:0];

endmodule

`default_nettype wire

//--- hqm_rf_init_cnt.sv
`timescale 1ns/1ps
`default_nettype none

module hqm_rf_init_cnt #(
     parameter int CNT_W = 8
) (
     input  logic                 wclk
    ,input  logic                 rst_n
    ,input  logic                 clear_en
    ,output hqm_rf_pkg::rf_addr_t clear_addr
    ,output logic                 clear_last
);

    // Count value of the final entry in the sweep
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(hqm_rf_pkg::RF_DEPTH - 1);

    logic [CNT_W-1:0] cnt_q;

    // Step once for every cycle the sweep is active
    // After the last entry the count wraps to zero and then sits idle
    always_ff @(posedge wclk) begin
        if (!rst_n) begin
            cnt_q <= '0;
        end else if (clear_en) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // The count doubles as the sweep write address
    assign clear_addr = hqm_rf_pkg::rf_addr_t'(cnt_q);

    // Flags the cycle that writes the final entry
    assign clear_last = (cnt_q == LAST_CNT);

endmodule

`default_nettype wire

//--- hqm_rf_init_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module hqm_rf_init_fsm (
     input  logic wclk
    ,input  logic rst_n
    ,input  logic clear_last
    ,output logic clear_en
    ,output logic init_done
);

    hqm_rf_ctrl_pkg::init_state_t state_q;
    hqm_rf_ctrl_pkg::init_state_t state_d;

    // ----------------------------------------------------------------------
    // Next state
    // ----------------------------------------------------------------------

    always_comb begin
        state_d = state_q;
        case (state_q)
            hqm_rf_ctrl_pkg::INIT_RESET: begin
                // First edge out of reset starts the sweep
                state_d = hqm_rf_ctrl_pkg::INIT_CLEAR;
            end
            hqm_rf_ctrl_pkg::INIT_CLEAR: begin
                // Leave once the final entry has been written
                if (clear_last) begin
                    state_d = hqm_rf_ctrl_pkg::INIT_DONE;
                end
            end
            hqm_rf_ctrl_pkg::INIT_DONE: begin
                // Terminal until the next reset
                state_d = hqm_rf_ctrl_pkg::INIT_DONE;
            end
            default: begin
                state_d = hqm_rf_ctrl_pkg::INIT_RESET;
            end
        endcase
    end

    // ----------------------------------------------------------------------
    // State register
    // ----------------------------------------------------------------------

    always_ff @(posedge wclk) begin
        if (!rst_n) begin
            state_q <= hqm_rf_ctrl_pkg::INIT_RESET;
        end else begin
            state_q <= state_d;
        end
    end

    // Outputs decode straight from the state, so they can never overlap
    assign clear_en  = (state_q == hqm_rf_ctrl_pkg::INIT_CLEAR);
    assign init_done = (state_q == hqm_rf_ctrl_pkg::INIT_DONE);

endmodule

`default_nettype wire

//--- hqm_rf_wr_mux.sv
`timescale 1ns/1ps
`default_nettype none

module hqm_rf_wr_mux (
     input  logic                 clear_en
    ,input  logic                 init_done
    ,input  hqm_rf_pkg::rf_addr_t clear_addr

    ,input  logic                 fn_we
    ,input  hqm_rf_pkg::rf_addr_t fn_waddr
    ,input  hqm_rf_pkg::rf_data_t fn_wdata
    ,input  logic                 fn_re

    ,output logic                 arr_we
    ,output hqm_rf_pkg::rf_addr_t arr_waddr
    ,output hqm_rf_pkg::rf_data_t arr_wdata
    ,output logic                 arr_re
);

    // Write side ownership
    // The sweep owns the port while it runs and writes every cycle
    // Afterwards the functional port owns it but only once init is done
    always_comb begin
        if (clear_en) begin
            arr_we    = 1'b1;
            arr_waddr = clear_addr;
            arr_wdata = hqm_rf_ctrl_pkg::INIT_CLEAR_VALUE;
        end else begin
            arr_we    = fn_we & init_done;
            arr_waddr = fn_waddr;
            arr_wdata = fn_wdata;
        end
    end

    // Reads before init would only return stale or uncleared words
    assign arr_re = fn_re & init_done;

endmodule

`default_nettype wire

//--- hqm_rf_store_top.sv
`timescale 1ns/1ps
`default_nettype none

module hqm_rf_store_top #(
     parameter int CNT_W = hqm_rf_pkg::RF_ADDR_W
) (
     input  logic                 wclk
    ,input  logic                 rclk
    ,input  logic                 rst_n

    ,input  logic                 we
    ,input  hqm_rf_pkg::rf_addr_t waddr
    ,input  hqm_rf_pkg::rf_data_t wdata

    ,input  logic                 re
    ,input  hqm_rf_pkg::rf_addr_t raddr

    ,output hqm_rf_pkg::rf_data_t rdata
    ,output logic                 init_done
);

    // Sweep control between state machine, counter and selector
    logic                 clear_en;
    logic                 clear_last;
    hqm_rf_pkg::rf_addr_t clear_addr;

    // Selected write path and gated read strobe toward the wrapper
    logic                 arr_we;
    hqm_rf_pkg::rf_addr_t arr_waddr;
    hqm_rf_pkg::rf_data_t arr_wdata;
    logic                 arr_re;

    // ----------------------------------------------------------------------
    // Initialization control
    // ----------------------------------------------------------------------

    hqm_rf_init_fsm i_hqm_rf_init_fsm (
         .wclk       (wclk)
        ,.rst_n      (rst_n)
        ,.clear_last (clear_last)
        ,.clear_en   (clear_en)
        ,.init_done  (init_done)
    );

    hqm_rf_init_cnt #(
         .CNT_W (CNT_W)
    ) i_hqm_rf_init_cnt (
         .wclk       (wclk)
        ,.rst_n      (rst_n)
        ,.clear_en   (clear_en)
        ,.clear_addr (clear_addr)
        ,.clear_last (clear_last)
    );

    // ----------------------------------------------------------------------
    // Access selection and storage
    // ----------------------------------------------------------------------

    hqm_rf_wr_mux i_hqm_rf_wr_mux (
         .clear_en   (clear_en)
        ,.init_done  (init_done)
        ,.clear_addr (clear_addr)
        ,.fn_we      (we)
        ,.fn_waddr   (waddr)
        ,.fn_wdata   (wdata)
        ,.fn_re      (re)
        ,.arr_we     (arr_we)
        ,.arr_waddr  (arr_waddr)
        ,.arr_wdata  (arr_wdata)
        ,.arr_re     (arr_re)
    );

    // Read address goes straight through since read gating is on re alone
    hqm_aw_rf_256x129 i_hqm_aw_rf_256x129 (
         .wclk       (wclk)
        ,.we         (arr_we)
        ,.waddr      (arr_waddr)
        ,.wdata      (arr_wdata)
        ,.rclk       (rclk)
        ,.re         (arr_re)
        ,.raddr      (raddr)
        ,.rdata      (rdata)
        ,.ip_reset_b (rst_n)
    );

endmodule

`default_nettype wire

//--- hqm_rf_store_assert.sv
`timescale 1ns/1ps
`default_nettype none

module hqm_rf_store_assert (
     input logic                 wclk
    ,input logic                 rst_n
    ,input logic                 init_done
    ,input logic                 clear_en
    ,input logic                 arr_we
    ,input hqm_rf_pkg::rf_addr_t arr_waddr
    ,input hqm_rf_pkg::rf_data_t arr_wdata
    ,input hqm_rf_pkg::rf_addr_t clear_addr
);

    // ----------------------------------------------------------------------
    // Init sequencing
    // ----------------------------------------------------------------------

    // Once the sweep has finished the array stays with the functional port
    property init_done_sticky;
        @(posedge wclk) disable iff (!rst_n)
        init_done |=> init_done;
    endproperty

    // The state decode keeps sweep and ready apart
    property sweep_excludes_done;
        @(posedge wclk) disable iff (!rst_n)
        !(clear_en && init_done);
    endproperty

    // ----------------------------------------------------------------------
    // Write gating
    // ----------------------------------------------------------------------

    // Before init_done the only array write allowed is the sweep's own
    // It must carry the counter address and the clear word
    property no_early_write;
        @(posedge wclk) disable iff (!rst_n)
        (arr_we && !init_done) |->
            (clear_en && arr_waddr == clear_addr
             && arr_wdata == hqm_rf_ctrl_pkg::INIT_CLEAR_VALUE);
    endproperty

    a_init_done_sticky: assert property (init_done_sticky)
        else $error("init_done fell after it had risen");

    a_sweep_excludes_done: assert property (sweep_excludes_done)
        else $error("clear_en and init_done are high together");

    a_no_early_write: assert property (no_early_write)
        else $error("functional write reached the array before init_done");

endmodule

bind hqm_rf_store_top hqm_rf_store_assert i_hqm_rf_store_assert (
     .wclk       (wclk)
    ,.rst_n      (rst_n)
    ,.init_done  (init_done)
    ,.clear_en   (clear_en)
    ,.arr_we     (arr_we)
    ,.arr_waddr  (arr_waddr)
    ,.arr_wdata  (arr_wdata)
    ,.clear_addr (clear_addr)
);

`default_nettype wire

//--- tb_hqm_rf_store.sv
`timescale 1ns/1ps
`default_nettype none

module tb_hqm_rf_store;

    // ----------------------------------------------------------------------
    // Run limits and stimulus operation codes
    // ----------------------------------------------------------------------

    localparam int MAX_LINES    = 64;
    localparam int RESET_CYC    = 10;
    // One edge to leave INIT_RESET plus one edge per cleared entry
    localparam int INIT_EDGES   = hqm_rf_pkg::RF_DEPTH + 1;
    localparam int INIT_LIMIT   = 400;
    // Init-phase writes start late so they target entries the sweep already cleared
    localparam int LATE_WR_EDGE = 240;

    localparam logic [7:0] OP_WRITE      = 8'h0;
    localparam logic [7:0] OP_RAND_WRITE = 8'h1;
    localparam logic [7:0] OP_READ       = 8'h2;
    localparam logic [7:0] OP_READ_MODEL = 8'h3;
    localparam logic [7:0] OP_INIT_WRITE = 8'h4;
    localparam logic [7:0] OP_READ_WRITE = 8'h5;
    localparam logic [7:0] OP_HOLD       = 8'h6;

    logic                 clk;
    logic                 rst_n;
    logic                 we;
    hqm_rf_pkg::rf_addr_t waddr;
    hqm_rf_pkg::rf_data_t wdata;
    logic                 re;
    hqm_rf_pkg::rf_addr_t raddr;
    hqm_rf_pkg::rf_data_t rdata;
    logic                 init_done;

    // Parsed stimulus lines
    logic [7:0]           op_mem   [MAX_LINES];
    hqm_rf_pkg::rf_addr_t addr_mem [MAX_LINES];
    hqm_rf_pkg::rf_data_t data_mem [MAX_LINES];
    int                   n_lines;

    // Expected content of every entry, zero after the sweep
    hqm_rf_pkg::rf_data_t ref_mem [hqm_rf_pkg::RF_DEPTH];

    integer seed;
    int     errors;
    int     checks;
    int     tests_run;
    int     tests_failed;
    logic   aborted;

    // Both array clocks come from the same source
    always #2 clk = ~clk;

    hqm_rf_store_top #(
         .CNT_W (hqm_rf_pkg::RF_ADDR_W)
    ) i_hqm_rf_store_top (
         .wclk      (clk)
        ,.rclk      (clk)
        ,.rst_n     (rst_n)
        ,.we        (we)
        ,.waddr     (waddr)
        ,.wdata     (wdata)
        ,.re        (re)
        ,.raddr     (raddr)
        ,.rdata     (rdata)
        ,.init_done (init_done)
    );

    // ----------------------------------------------------------------------
    // Compare tasks
    // ----------------------------------------------------------------------

    task automatic check_data(
        input hqm_rf_pkg::rf_data_t actual,
        input hqm_rf_pkg::rf_data_t expected,
        input string                what
    );
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR at %0t: %s: expected %h, got %h", $time, what, expected, actual);
        end
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR at %0t: %s: expected %b, got %b", $time, what, expected, actual);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors > errors_before) begin
            tests_failed++;
            $display("Test %0d %s: FAIL", tests_run, name);
        end else begin
            $display("Test %0d %s: PASS", tests_run, name);
        end
    endtask

    function automatic string op_name(input logic [7:0] op);
        case (op)
            OP_WRITE:      return "write";
            OP_RAND_WRITE: return "random write";
            OP_READ:       return "read";
            OP_READ_MODEL: return "model read";
            OP_INIT_WRITE: return "init write";
            OP_READ_WRITE: return "read with write";
            OP_HOLD:       return "hold";
            default:       return "unknown";
        endcase
    endfunction

    // Five draws cover the 129 data bits, the top ones are dropped
    function automatic hqm_rf_pkg::rf_data_t random_word();
        logic [159:0] raw;
        raw = {$random(seed), $random(seed), $random(seed), $random(seed), $random(seed)};
        return raw[hqm_rf_pkg::RF_DATA_W-1:0];
    endfunction

    // ----------------------------------------------------------------------
    // Stimulus file
    // ----------------------------------------------------------------------

    task automatic load_stimulus();
        int                   fd;
        int                   fields;
        string                line;
        logic [7:0]           op;
        hqm_rf_pkg::rf_addr_t addr;
        hqm_rf_pkg::rf_data_t data;
        n_lines = 0;
        fd = $fopen("hqm_rf_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file hqm_rf_input.txt");
            aborted = 1'b1;
        end else begin
            while (!$feof(fd) && n_lines < MAX_LINES) begin
                line = "";
                if ($fgets(line, fd) != 0) begin
                    // Comment and blank lines do not scan as three fields
                    fields = $sscanf(line, "%h %h %h", op, addr, data);
                    if (fields == 3) begin
                        op_mem[n_lines]   = op;
                        addr_mem[n_lines] = addr;
                        data_mem[n_lines] = data;
                        n_lines++;
                    end
                end
            end
            $fclose(fd);
            if (n_lines == 0) begin
                $display("The stimulus file holds no operations");
                aborted = 1'b1;
            end
        end
    endtask

    // ----------------------------------------------------------------------
    // Port drivers, each entered and left on a falling edge
    // ----------------------------------------------------------------------

    task automatic drive_write(
        input hqm_rf_pkg::rf_addr_t addr,
        input hqm_rf_pkg::rf_data_t data
    );
        we    = 1'b1;
        waddr = addr;
        wdata = data;
        @(negedge clk);
        we    = 1'b0;
    endtask

    // Read data is registered on the edge that takes re
    task automatic read_word(
        input  hqm_rf_pkg::rf_addr_t addr,
        output hqm_rf_pkg::rf_data_t data
    );
        re    = 1'b1;
        raddr = addr;
        @(negedge clk);
        data  = rdata;
        re    = 1'b0;
    endtask

    // ----------------------------------------------------------------------
    // Test phases
    // ----------------------------------------------------------------------

    task automatic run_reset();
        int errors_before;
        errors_before = errors;
        rst_n = 1'b0;
        repeat (RESET_CYC) begin
            @(negedge clk);
            check_flag(init_done, 1'b0, "init_done during reset");
        end
        // Output register clears as soon as the synchronized IP reset drops
        check_data(rdata, '0, "rdata during reset");
        report_test("reset", errors_before);
    endtask

    task automatic run_init();
        int errors_before;
        int edges;
        int late_idx;
        errors_before = errors;
        edges         = 0;
        late_idx      = 0;
        rst_n         = 1'b1;
        while (init_done !== 1'b1 && edges < INIT_LIMIT) begin
            @(posedge clk);
            edges++;
            @(negedge clk);
            check_flag(init_done, edges >= INIT_EDGES,
                       $sformatf("init_done after edge %0d", edges));
            we = 1'b0;
            // Last slot is sampled on the final sweep edge, still before init_done
            if (edges >= LATE_WR_EDGE && edges < INIT_EDGES) begin
                while (late_idx < n_lines && op_mem[late_idx] != OP_INIT_WRITE) begin
                    late_idx++;
                end
                if (late_idx < n_lines) begin
                    we    = 1'b1;
                    waddr = addr_mem[late_idx];
                    wdata = data_mem[late_idx];
                    late_idx++;
                end
            end
        end
        we = 1'b0;
        if (init_done !== 1'b1) begin
            $display("Timeout: init_done did not rise within %0d cycles after reset release",
                     INIT_LIMIT);
            aborted = 1'b1;
        end
        report_test("init sweep", errors_before);
    endtask

    task automatic run_line(input int idx);
        int                   errors_before;
        int                   hold_cycles;
        int                   i;
        logic [7:0]           op;
        hqm_rf_pkg::rf_addr_t addr;
        hqm_rf_pkg::rf_data_t data;
        hqm_rf_pkg::rf_data_t got;
        hqm_rf_pkg::rf_data_t fill;
        errors_before = errors;
        op            = op_mem[idx];
        addr          = addr_mem[idx];
        data          = data_mem[idx];
        case (op)
            OP_WRITE: begin
                drive_write(addr, data);
                ref_mem[addr] = data;
            end
            OP_RAND_WRITE: begin
                fill = random_word();
                drive_write(addr, fill);
                ref_mem[addr] = fill;
            end
            OP_READ: begin
                read_word(addr, got);
                check_data(got, data, $sformatf("read of entry %h", addr));
            end
            OP_READ_MODEL, OP_INIT_WRITE: begin
                // A write issued during init must have left the cleared word in place
                read_word(addr, got);
                check_data(got, ref_mem[addr], $sformatf("read of entry %h", addr));
            end
            OP_READ_WRITE: begin
                re    = 1'b1;
                raddr = addr;
                we    = 1'b1;
                waddr = addr;
                wdata = data;
                @(negedge clk);
                got = rdata;
                re  = 1'b0;
                we  = 1'b0;
                check_data(got, ref_mem[addr], "read on the write edge");
                ref_mem[addr] = data;
                read_word(addr, got);
                check_data(got, ref_mem[addr], "read after the write");
            end
            OP_HOLD: begin
                hold_cycles = int'(data[7:0]);
                read_word(addr, got);
                check_data(got, ref_mem[addr], $sformatf("read of entry %h", addr));
                // Move the read address so only the output register can keep the word
                for (i = 0; i < hold_cycles; i++) begin
                    raddr = addr + hqm_rf_pkg::rf_addr_t'(i + 1);
                    @(negedge clk);
                    check_data(rdata, ref_mem[addr], "rdata hold with re low");
                end
            end
            default: begin
                errors++;
                $display("Unknown operation %h on stimulus line %0d", op, idx);
            end
        endcase
        report_test($sformatf("line %0d %s at %h", idx, op_name(op), addr), errors_before);
    endtask

    task automatic run_all_lines();
        int idx;
        for (idx = 0; idx < n_lines; idx++) begin
            run_line(idx);
        end
    endtask

    task automatic clear_model();
        int a;
        for (a = 0; a < hqm_rf_pkg::RF_DEPTH; a++) begin
            ref_mem[a] = '0;
        end
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        we           = 1'b0;
        waddr        = '0;
        wdata        = '0;
        re           = 1'b0;
        raddr        = '0;
        seed         = 32'h453b;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        aborted      = 1'b0;
        clear_model();
        load_stimulus();
        if (!aborted) begin
            run_reset();
            run_init();
        end
        if (!aborted) begin
            run_all_lines();
        end
        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (!aborted && errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hqm_rf_input.txt
# Stimulus for tb_hqm_rf_store, one operation per line, all fields in hex
# Columns: op addr data; op 0 write, 1 random write, 2 read vs data, 3 read vs model,
# 4 write issued during init then read, 5 read and write on one edge, 6 read then hold
4 05 1ffffffffffffffffffffffffffffffff
4 20 0a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5
4 c3 10123456789abcdef0123456789abcdef
2 00 0
2 ff 0
2 7e 0
2 31 0
0 10 1deadbeefcafef00d0123456789abcdef
2 10 1deadbeefcafef00d0123456789abcdef
0 ff 100000000000000000000000000000001
2 ff 100000000000000000000000000000001
0 00 0ffffffffffffffffffffffffffffffff
2 00 0ffffffffffffffffffffffffffffffff
2 01 0
1 44 0
3 44 0
1 9a 0
3 9a 0
5 10 00123456789abcdef0123456789abcdef
6 10 4
5 ff 1f0f0f0f0e1e1e1e1d2d2d2d2c3c3c3c3
3 ff 0
6 44 3

//--- compile.f
hqm_rf_pkg.sv
hqm_rf_ctrl_pkg.sv
hqm_mem_reset_sync.sv
hqm_rf_array.sv
hqm_aw_rf_256x129.sv
hqm_rf_init_cnt.sv
hqm_rf_init_fsm.sv
hqm_rf_wr_mux.sv
hqm_rf_store_top.sv
hqm_rf_store_assert.sv
tb_hqm_rf_store.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the storage block testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_hqm_rf_store \
    -f compile.f

# The simulation status is taken from the log, not from the exit code
./obj_dir/Vtb_hqm_rf_store | tee sim.log

if grep -qx "Verification passed" sim.log; then
    echo "Simulation PASS"
    exit 0
else
    echo "Simulation FAIL"
    exit 1
fi
